// File: Bender.yml
package:
  name: control_unit

export_include_dirs:
  - .

sources:
  - ctrl_isa_pkg.sv
  - ctrl_datapath_pkg.sv
  - step_if.sv
  - instr_decoder.sv
  - step_sequencer.sv
  - control_encoder.sv
  - control_unit.sv
  - target: test
    files:
      - tb_control_unit.sv

// File: control_encoder.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module control_encoder import ctrl_isa_pkg::*; import ctrl_datapath_pkg::*; (
        input logic clk,
        input logic reset,
        step_if.enc step_bus,
        output pc_src_t pc_src,
        output alu_src_a_t alu_src_a,
        output alu_src_b_t alu_src_b,
        output alu_op_t alu_op,
        output iord_t iord,
        output reg_dst_t reg_dst,
        output reg_data_t reg_data,
        output logic wr,
        output logic ir_write,
        output logic pc_write,
        output logic bank_write,
        output logic epc_write,
        output logic a_write,
        output logic b_write,
        output logic alu_out_write,
        output logic mem_reg_write
);

        logic is_addi;

        assign is_addi = (step_bus.instr_class == cls_addi);

        always_ff @(posedge clk) begin
                // Defaults give PC + 4 on the instruction address
                pc_src <= pc_alu_out;
                alu_src_a <= src_a_pc;
                alu_src_b <= src_b_four;
                alu_op <= alu_add;
                iord <= iord_pc;
                reg_dst <= dst_rt;
                reg_data <= data_alu;
                {wr, ir_write, pc_write, bank_write, epc_write} <= '0;
                {a_write, b_write, alu_out_write, mem_reg_write} <= '0;

                if (!reset) begin
                        case (step_bus.phase)
                                ph_fetch: begin
                                        if (step_bus.step < step_t'(`FETCH_READ_STEPS)) begin
                                                alu_out_write <= 1'b1;
                                        end else begin
                                                ir_write <= 1'b1;
                                                pc_write <= 1'b1;
                                        end
                                end
                                ph_decode: begin
                                        if (step_bus.step == '0) begin
                                                alu_src_b <= src_b_branch;  // Early branch target
                                                a_write <= 1'b1;
                                                b_write <= 1'b1;
                                                alu_out_write <= 1'b1;
                                        end
                                end
                                ph_alu: begin
                                        alu_src_a <= src_a_reg;
                                        alu_src_b <= is_addi ? src_b_imm : src_b_reg;
                                        reg_dst <= is_addi ? dst_rt : dst_rd;
                                        case (step_bus.instr_class)
                                                cls_sub: alu_op <= alu_sub;
                                                cls_and: alu_op <= alu_and;
                                                default: alu_op <= alu_add;
                                        endcase
                                        if (step_bus.step == '0)
                                                alu_out_write <= 1'b1;
                                        else if (step_bus.exc_code == '0)
                                                bank_write <= 1'b1;
                                end
                                ph_branch: begin
                                        alu_src_a <= src_a_reg;
                                        alu_src_b <= src_b_reg;
                                        alu_op <= alu_cmp;
                                end
                                ph_branch_write: pc_write <= 1'b1;
                                ph_mem: begin
                                        alu_src_a <= src_a_reg;
                                        alu_src_b <= src_b_imm;
                                        if (step_bus.step == '0)
                                                alu_out_write <= 1'b1;
                                        else
                                                iord <= iord_alu;
                                        if (step_bus.step == step_t'(`MEM_ADDR_STEPS - 1))
                                                mem_reg_write <= 1'b1;
                                end
                                ph_load: begin
                                        reg_data <= data_mem;
                                        bank_write <= 1'b1;
                                end
                                ph_store: begin
                                        iord <= iord_alu;
                                        wr <= 1'b1;
                                end
                                ph_jump: begin
                                        pc_src <= pc_offset;
                                        pc_write <= 1'b1;
                                end
                                ph_exception: begin
                                        pc_src <= pc_load;
                                        if (step_bus.step < step_t'(`EXC_READ_STEPS)) begin
                                                alu_op <= alu_sub;  // EPC gets PC - 4
                                                iord <= step_bus.exc_code;
                                                epc_write <= 1'b1;
                                                mem_reg_write <= 1'b1;
                                        end else begin
                                                pc_write <= 1'b1;
                                        end
                                end
                                default: ;
                        endcase
                end
        end

        a_ir_with_pc: assert property (@(posedge clk) disable iff (reset)
                ir_write |-> pc_write);

        a_bank_not_wr: assert property (@(posedge clk) disable iff (reset)
                !(bank_write && wr));

        // Target write only after the sequencer saw the branch condition
        a_branch_write: assert property (@(posedge clk) disable iff (reset)
                step_bus.phase == ph_branch_write |-> $past(step_bus.branch_taken));

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit import ctrl_isa_pkg::*; import ctrl_datapath_pkg::*; (
        input logic clk,
        input logic reset,
        input opcode_t op,
        input funct_t funct,
        input logic zero,
        input logic overflow,
        input logic eq,
        output pc_src_t pc_src,
        output alu_src_a_t alu_src_a,
        output alu_src_b_t alu_src_b,
        output alu_op_t alu_op,
        output iord_t iord,
        output reg_dst_t reg_dst,
        output reg_data_t reg_data,
        output logic wr,
        output logic ir_write,
        output logic pc_write,
        output logic bank_write,
        output logic epc_write,
        output logic a_write,
        output logic b_write,
        output logic alu_out_write,
        output logic mem_reg_write
);

        instr_class_t instr_class;
        logic decode_capture;

        step_if step_bus ();

        instr_decoder u_decoder (
                .clk            (clk),
                .reset          (reset),
                .op             (op),
                .funct          (funct),
                .decode_capture (decode_capture),
                .instr_class    (instr_class)
        );

        step_sequencer u_sequencer (
                .clk            (clk),
                .reset          (reset),
                .instr_class    (instr_class),
                .overflow       (overflow),
                .eq             (eq),
                .decode_capture (decode_capture),
                .step_bus       (step_bus.seq)
        );

        control_encoder u_encoder (
                .clk           (clk),
                .reset         (reset),
                .step_bus      (step_bus.enc),
                .pc_src        (pc_src),
                .alu_src_a     (alu_src_a),
                .alu_src_b     (alu_src_b),
                .alu_op        (alu_op),
                .iord          (iord),
                .reg_dst       (reg_dst),
                .reg_data      (reg_data),
                .wr            (wr),
                .ir_write      (ir_write),
                .pc_write      (pc_write),
                .bank_write    (bank_write),
                .epc_write     (epc_write),
                .a_write       (a_write),
                .b_write       (b_write),
                .alu_out_write (alu_out_write),
                .mem_reg_write (mem_reg_write)
        );

endmodule

// File: ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Instruction fields
`define OP_W 6
`define FUNCT_W 6

// Step counter
`define STEP_W 3

// Memory read steps before the instruction register loads
`define FETCH_READ_STEPS 3

`define MEM_ADDR_STEPS 4    // Address calc plus wait steps
`define EXC_READ_STEPS 3    // Vector read steps

// iord codes that select the exception vector address
`define EXC_OP_INEX 3'd3
`define EXC_OVERFLOW 3'd4

`endif

// File: ctrl_datapath_pkg.sv
package ctrl_datapath_pkg;

        typedef enum logic [1:0] {
                pc_alu_out = 2'b00,
                pc_offset  = 2'b01,     // Jump target
                pc_load    = 2'b10      // Vector from memory
        } pc_src_t;

        typedef enum logic [1:0] {
                src_a_pc  = 2'b00,
                src_a_reg = 2'b10
        } alu_src_a_t;

        typedef enum logic [1:0] {
                src_b_reg    = 2'b00,
                src_b_four   = 2'b01,
                src_b_imm    = 2'b10,
                src_b_branch = 2'b11    // Shifted offset
        } alu_src_b_t;

        typedef enum logic [2:0] {
                alu_add = 3'b001,
                alu_sub = 3'b010,
                alu_and = 3'b011,
                alu_cmp = 3'b111
        } alu_op_t;

        typedef logic [2:0] iord_t;

        localparam iord_t iord_pc  = 3'd0;
        localparam iord_t iord_alu = 3'd1;

        typedef enum logic [2:0] {dst_rt = 3'b000, dst_rd = 3'b001} reg_dst_t;

        typedef enum logic [2:0] {data_alu = 3'b000, data_mem = 3'b001} reg_data_t;

endpackage

// File: ctrl_isa_pkg.sv
`include "ctrl_cfg.svh"

package ctrl_isa_pkg;

        typedef logic [`OP_W-1:0] opcode_t;
        typedef logic [`FUNCT_W-1:0] funct_t;
        typedef logic [`STEP_W-1:0] step_t;
        typedef logic [2:0] exc_code_t;

        // Opcodes
        localparam opcode_t op_rtype = 6'h00;
        localparam opcode_t op_j     = 6'h02;
        localparam opcode_t op_beq   = 6'h04;
        localparam opcode_t op_bne   = 6'h05;
        localparam opcode_t op_addi  = 6'h08;
        localparam opcode_t op_lw    = 6'h23;
        localparam opcode_t op_sw    = 6'h2b;

        // R-type function codes
        localparam funct_t fn_add = 6'h20;
        localparam funct_t fn_sub = 6'h22;
        localparam funct_t fn_and = 6'h24;

        typedef enum logic [3:0] {
                cls_add, cls_sub, cls_and, cls_addi,
                cls_beq, cls_bne, cls_lw, cls_sw,
                cls_j, cls_invalid
        } instr_class_t;

        typedef enum logic [3:0] {
                ph_fetch,
                ph_decode,
                ph_alu,
                ph_branch,
                ph_branch_write,
                ph_mem,
                ph_load,
                ph_store,
                ph_jump,
                ph_exception
        } phase_t;

endpackage

// File: flist.f
+incdir+.
ctrl_isa_pkg.sv
ctrl_datapath_pkg.sv
step_if.sv
instr_decoder.sv
step_sequencer.sv
control_encoder.sv
control_unit.sv
tb_control_unit.sv

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import ctrl_isa_pkg::*; (
        input logic clk,
        input logic reset,
        input opcode_t op,
        input funct_t funct,
        input logic decode_capture,
        output instr_class_t instr_class
);

        instr_class_t class_d;

        always_comb begin
                class_d = cls_invalid;
                case (op)
                        op_rtype: begin
                                case (funct)
                                        fn_add: class_d = cls_add;
                                        fn_sub: class_d = cls_sub;
                                        fn_and: class_d = cls_and;
                                        default: class_d = cls_invalid;
                                endcase
                        end
                        op_addi: class_d = cls_addi;
                        op_beq: class_d = cls_beq;
                        op_bne: class_d = cls_bne;
                        op_lw: class_d = cls_lw;
                        op_sw: class_d = cls_sw;
                        op_j: class_d = cls_j;
                        default: class_d = cls_invalid;
                endcase
        end

        // Held for the rest of the instruction
        always_ff @(posedge clk) begin
                if (reset) begin
                        instr_class <= cls_invalid;
                end else if (decode_capture) begin
                        instr_class <= class_d;
                end
        end

endmodule

// File: step_if.sv
`timescale 1ns/1ps

interface step_if import ctrl_isa_pkg::*; ();

        phase_t phase;
        step_t step;
        exc_code_t exc_code;            // Zero unless an exception is pending or active
        logic branch_taken;
        instr_class_t instr_class;

        modport seq (
                output phase, step, exc_code, branch_taken, instr_class
        );

        modport enc (
                input phase, step, exc_code, branch_taken, instr_class
        );

endinterface

// File: step_sequencer.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module step_sequencer import ctrl_isa_pkg::*; (
        input logic clk,
        input logic reset,
        input instr_class_t instr_class,
        input logic overflow,
        input logic eq,
        output logic decode_capture,
        step_if.seq step_bus
);

        phase_t phase;
        phase_t phase_d;
        step_t step;
        exc_code_t exc_q;
        logic at_last;
        logic checks_ovf;
        logic ovf_trap;
        logic taken;

        function automatic step_t last_step(phase_t ph);
                case (ph)
                        ph_fetch: return step_t'(`FETCH_READ_STEPS);
                        ph_decode, ph_alu: return step_t'(1);
                        ph_mem: return step_t'(`MEM_ADDR_STEPS - 1);
                        ph_exception: return step_t'(`EXC_READ_STEPS);
                        default: return '0;
                endcase
        endfunction

        assign at_last = (step == last_step(phase));
        assign decode_capture = (phase == ph_decode) && (step == '0);

        assign checks_ovf = (instr_class == cls_add) || (instr_class == cls_sub) ||
                            (instr_class == cls_addi);
        assign ovf_trap = (phase == ph_alu) && at_last && checks_ovf && overflow;

        // bne takes the branch on unequal operands
        assign taken = (phase == ph_branch) && ((instr_class == cls_beq) ? eq : !eq);

        always_comb begin
                phase_d = ph_fetch;
                case (phase)
                        ph_fetch: phase_d = ph_decode;
                        ph_decode: begin
                                case (instr_class)
                                        cls_add, cls_sub, cls_and, cls_addi: phase_d = ph_alu;
                                        cls_beq, cls_bne: phase_d = ph_branch;
                                        cls_lw, cls_sw: phase_d = ph_mem;
                                        cls_j: phase_d = ph_jump;
                                        default: phase_d = ph_exception;
                                endcase
                        end
                        ph_alu: phase_d = ovf_trap ? ph_exception : ph_fetch;
                        ph_branch: phase_d = taken ? ph_branch_write : ph_fetch;
                        ph_mem: phase_d = (instr_class == cls_sw) ? ph_store : ph_load;
                        default: phase_d = ph_fetch;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        phase <= ph_fetch;
                        step <= '0;
                        exc_q <= '0;
                end else if (!at_last) begin
                        step <= step + step_t'(1);
                end else begin
                        phase <= phase_d;
                        step <= '0;
                        if (phase_d == ph_exception) begin
                                exc_q <= (phase == ph_decode) ? exc_code_t'(`EXC_OP_INEX) :
                                                                exc_code_t'(`EXC_OVERFLOW);
                        end else begin
                                exc_q <= '0;
                        end
                end
        end

        assign step_bus.phase = phase;
        assign step_bus.step = step;
        assign step_bus.branch_taken = taken;
        assign step_bus.instr_class = instr_class;
        // Overflow shows up early so the encoder can drop the write
        assign step_bus.exc_code = ovf_trap ? exc_code_t'(`EXC_OVERFLOW) : exc_q;

        a_step_range: assert property (@(posedge clk) disable iff (reset)
                step <= last_step(phase));

endmodule

// File: tb_control_unit.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module tb_control_unit import ctrl_isa_pkg::*; import ctrl_datapath_pkg::*; ();

        localparam int clk_period = 40;
        localparam int reset_cycles = 16;
        localparam int n_instr = 60;
        localparam int max_instr_cycles = 12;   // Overflow trap
        localparam int timeout_cycles = n_instr * max_instr_cycles + reset_cycles + 50;

        typedef struct packed {
                instr_class_t cls;
                logic ovf;
                logic eq;
        } instr_t;

        typedef struct packed {
                logic [7:0] cycles;
                logic [7:0] banks;
                logic [7:0] wrs;
                logic [7:0] epcs;
                logic [7:0] pcs;
                logic [7:0] loads;
                logic [2:0] iord;
                reg_dst_t dst;
                reg_data_t data;
                alu_op_t op;
                alu_src_b_t src_b;
        } expect_t;

        logic clk = 1'b0;
        logic reset;
        opcode_t op;
        funct_t funct;
        logic zero;
        logic overflow;
        logic eq;
        pc_src_t pc_src;
        alu_src_a_t alu_src_a;
        alu_src_b_t alu_src_b;
        alu_op_t alu_op;
        iord_t iord;
        reg_dst_t reg_dst;
        reg_data_t reg_data;
        logic wr;
        logic ir_write;
        logic pc_write;
        logic bank_write;
        logic epc_write;
        logic a_write;
        logic b_write;
        logic alu_out_write;
        logic mem_reg_write;

        integer seed;
        int value_errors = 0;
        int other_errors = 0;
        int checked = 0;
        int since_reset = 0;
        bit first_seen = 1'b0;
        bit window_open = 1'b0;
        int win_cycles;
        int win_banks;
        int win_wrs;
        int win_epcs;
        int win_pcs;
        int win_loads;
        expect_t cur_exp;
        instr_t inflight[$];                    // Driven but not yet checked

        control_unit UUT (.*);

        always #(clk_period / 2) clk = ~clk;

        // Cycles and strobe counts from one ir_write up to the next
        function automatic expect_t expected_result(input instr_t ins);
                expect_t e;
                logic taken;
                e = '0;
                e.cycles = 8'd6;                // Fetch 4 plus decode 2
                e.pcs = 8'd1;                   // PC + 4 with ir_write
                taken = (ins.cls == cls_beq) ? ins.eq : !ins.eq;
                case (ins.cls)
                        cls_add, cls_sub, cls_addi: begin
                                if (ins.ovf) begin
                                        e.cycles = e.cycles + 8'd6;     // ALU then trap
                                        e.epcs = 8'd3;
                                        e.pcs = 8'd2;
                                        e.loads = 8'd1;
                                        e.iord = `EXC_OVERFLOW;
                                end else begin
                                        e.cycles = e.cycles + 8'd2;
                                        e.banks = 8'd1;
                                end
                        end
                        cls_and: begin
                                e.cycles = e.cycles + 8'd2;
                                e.banks = 8'd1;
                        end
                        cls_beq, cls_bne: begin
                                e.cycles = e.cycles + (taken ? 8'd2 : 8'd1);
                                e.pcs = taken ? 8'd2 : 8'd1;
                        end
                        cls_lw, cls_sw: begin
                                e.cycles = e.cycles + 8'd5;
                                e.banks = (ins.cls == cls_lw) ? 8'd1 : 8'd0;
                                e.wrs = (ins.cls == cls_sw) ? 8'd1 : 8'd0;
                        end
                        cls_j: begin
                                e.cycles = e.cycles + 8'd1;
                                e.pcs = 8'd2;
                        end
                        default: begin          // Invalid opcode trap
                                e.cycles = e.cycles + 8'd4;
                                e.epcs = 8'd3;
                                e.pcs = 8'd2;
                                e.loads = 8'd1;
                                e.iord = `EXC_OP_INEX;
                        end
                endcase
                // R-type writes rd, addi and lw write rt
                if (ins.cls == cls_add || ins.cls == cls_sub || ins.cls == cls_and)
                        e.dst = dst_rd;
                else
                        e.dst = dst_rt;
                e.data = (ins.cls == cls_lw) ? data_mem : data_alu;
                e.src_b = (ins.cls == cls_addi) ? src_b_imm : src_b_reg;
                if (ins.cls == cls_sub)
                        e.op = alu_sub;
                else if (ins.cls == cls_and)
                        e.op = alu_and;
                else
                        e.op = alu_add;
                return e;
        endfunction

        task automatic check_value(input string name, input int got, input int expected);
                assert (got == expected) else begin
                        $display("** Error at %0t ns: %s = %0d, expected %0d",
                                 $time, name, got, expected);
                        value_errors++;
                end
        endtask

        task automatic apply_instruction(input instr_t ins);
                int pick;
                op = op_rtype;
                funct = fn_add;
                case (ins.cls)
                        cls_sub: funct = fn_sub;
                        cls_and: funct = fn_and;
                        cls_addi: op = op_addi;
                        cls_beq: op = op_beq;
                        cls_bne: op = op_bne;
                        cls_lw: op = op_lw;
                        cls_sw: op = op_sw;
                        cls_j: op = op_j;
                        cls_invalid: begin
                                // Codes of instructions this unit does not run
                                pick = $unsigned($random(seed)) % 3;
                                if (pick == 0)
                                        op = 6'h0f;     // lui
                                else if (pick == 1)
                                        op = 6'h03;     // jal
                                else
                                        funct = 6'h2a;  // slt
                        end
                        default: ;
                endcase
                overflow = ins.ovf;
                eq = ins.eq;
        endtask

        task automatic close_window();
                check_value("cycles between ir_write", win_cycles, cur_exp.cycles);
                check_value("bank_write pulses", win_banks, cur_exp.banks);
                check_value("wr pulses", win_wrs, cur_exp.wrs);
                check_value("epc_write cycles", win_epcs, cur_exp.epcs);
                check_value("pc_write pulses", win_pcs, cur_exp.pcs);
                check_value("pc_write with pc_src load", win_loads, cur_exp.loads);
                inflight.delete(0);
                checked++;
        endtask

        initial begin
                instr_t ins;
                seed = 16;
                reset = 1'b1;
                op = '0;
                funct = '0;
                zero = 1'b0;
                overflow = 1'b0;
                eq = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                #2 reset = 1'b0;
                for (int i = 0; i < n_instr; i++) begin
                        do begin
                                @(posedge clk);
                                #2;
                        end while (!ir_write);
                        ins.cls = instr_class_t'($unsigned($random(seed)) % 10);
                        ins.ovf = $unsigned($random(seed)) % 2;
                        ins.eq = $unsigned($random(seed)) % 2;
                        apply_instruction(ins);
                        zero = $unsigned($random(seed)) % 2;    // Branches follow eq alone
                        inflight.push_back(ins);
                end
                wait (checked == n_instr);
                $display("Checked %0d instructions: %0d value errors, %0d other errors",
                         checked, value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

        always @(negedge clk) begin
                if (reset) begin
                        check_value("write strobes", {wr, ir_write, pc_write, bank_write,
                                    epc_write, a_write, b_write, alu_out_write, mem_reg_write}, 0);
                end else begin
                        if (!first_seen)
                                since_reset++;
                        if (ir_write) begin
                                if (!first_seen) begin
                                        assert (since_reset <= 5) else begin
                                                $display("First ir_write came %0d cycles %s",
                                                         since_reset, "after reset, more than 5");
                                                other_errors++;
                                        end
                                        first_seen = 1'b1;
                                end
                                assert (pc_write) else begin
                                        $display("ir_write at %0t ns came without pc_write", $time);
                                        other_errors++;
                                end
                                if (window_open)
                                        close_window();
                                window_open = 1'b1;
                                win_cycles = 0;
                                win_banks = 0;
                                win_wrs = 0;
                                win_epcs = 0;
                                win_pcs = 0;
                                win_loads = 0;
                                if (inflight.size() > 0)
                                        cur_exp = expected_result(inflight[0]);
                        end
                        if (window_open) begin
                                win_cycles++;
                                win_banks += bank_write;
                                win_wrs += wr;
                                win_epcs += epc_write;
                                win_pcs += pc_write;
                                if (pc_write && pc_src == pc_load)
                                        win_loads++;
                                if (epc_write)
                                        check_value("iord", iord, cur_exp.iord);  // Vector code
                                if (bank_write) begin
                                        check_value("reg_dst", reg_dst, cur_exp.dst);
                                        check_value("reg_data", reg_data, cur_exp.data);
                                        if (cur_exp.data == data_alu) begin
                                                check_value("alu_src_a", alu_src_a, src_a_reg);
                                                check_value("alu_src_b", alu_src_b,
                                                            cur_exp.src_b);
                                                check_value("alu_op", alu_op, cur_exp.op);
                                        end
                                end
                        end
                end
        end

        initial begin
                #(timeout_cycles * clk_period);
                $display("Watchdog: run did not finish within %0d cycles", timeout_cycles);
                $display("SOME TESTS FAILED");
                $finish;
        end

endmodule
